// File: tank_arena.f
+incdir+include
verilog/arena_pkg.sv
verilog/game_ctrl.sv
verilog/tank_mover.sv
verilog/shot_slots.sv
verilog/monster_row.sv
verilog/pixel_renderer.sv
verilog/tank_arena.sv
sim/tank_arena_tb.sv

// File: Bender.yml
package:
  name: tank_arena

export_include_dirs:
  - include

sources:
  - files:
      - verilog/arena_pkg.sv
      - verilog/game_ctrl.sv
      - verilog/tank_mover.sv
      - verilog/shot_slots.sv
      - verilog/monster_row.sv
      - verilog/pixel_renderer.sv
      - verilog/tank_arena.sv
  - target: simulation
    files:
      - sim/tank_arena_tb.sv

// File: sim/tank_arena_tb.sv
`default_nettype none
`include "arena_config.svh"

module tank_arena_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 100;
	// edges from the fire edge until a hit or a miss frees its slot
	localparam int hit_delay = 1 + 351;
	localparam int miss_delay = 1 + 418;
	localparam int hit_wait = 400;
	localparam int miss_wait = 420;
	// reset and tests 1 to 5 with random moves at their longest
	localparam int test_cycles = 5 + 10 + 410 + 1300 + 650 + 430;
	localparam int watchdog_ns = test_cycles * 6 / 5 * clk_period;

	logic clk;
	logic rst;
	logic bright;
	logic left;
	logic right;
	logic fire;
	logic level_next;
	arena_pkg::coord_t hcount;
	arena_pkg::coord_t vcount;
	arena_pkg::rgb_t rgb;
	arena_pkg::monster_mask_t monster_destroyed;
	arena_pkg::score_t score;

	// reference model state
	arena_pkg::coord_t model_x;
	arena_pkg::monster_mask_t model_mask;
	arena_pkg::monster_mask_t pending;
	arena_pkg::score_t model_score;
	int release_q[$];
	int cycle;
	int checks;
	int mismatches;
	integer seed;
	int n;

	tank_arena dut_i (
		.clk               (clk),
		.rst               (rst),
		.bright            (bright),
		.left              (left),
		.right             (right),
		.fire              (fire),
		.level_next        (level_next),
		.hcount            (hcount),
		.vcount            (vcount),
		.rgb               (rgb),
		.monster_destroyed (monster_destroyed),
		.score             (score)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog timeout: the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

	function automatic int monster_col(input int m);
		return `ARENA_MONSTER_X0 + `ARENA_MONSTER_PITCH * m;
	endfunction

	function automatic int count_bits(input arena_pkg::monster_mask_t mask);
		int total;
		total = 0;
		for (int i = 0; i < `ARENA_NUM_MONSTERS; i++) begin
			total = total + mask[i];
		end
		return total;
	endfunction

	// inputs change 10 ns after each rising edge
	task automatic tick();
		@(posedge clk);
		cycle = cycle + 1;
		#10;
	endtask

	task automatic step_right();
		right = 1'b1;
		tick();
		right = 1'b0;
		if (model_x == `ARENA_X_MAX) begin
			model_x = `ARENA_X_MIN;
		end else begin
			model_x = model_x + `ARENA_TANK_STEP;
		end
	endtask

	task automatic step_left();
		left = 1'b1;
		tick();
		left = 1'b0;
		if (model_x == `ARENA_X_MIN) begin
			model_x = `ARENA_X_MAX;
		end else begin
			model_x = model_x - `ARENA_TANK_STEP;
		end
	endtask

	task automatic move_to(input int target);
		while (model_x != target) begin
			if (model_x < target) begin
				step_right();
			end else begin
				step_left();
			end
		end
	endtask

	// the model picks the target monster when a slot is free
	task automatic press_fire();
		int kept[$];
		int mx;
		logic aimed;
		foreach (release_q[i]) begin
			if (release_q[i] > cycle) begin
				kept.push_back(release_q[i]);
			end
		end
		release_q = kept;
		if (release_q.size() < `ARENA_NUM_SHOTS) begin
			aimed = 1'b0;
			for (int m = 0; m < `ARENA_NUM_MONSTERS; m++) begin
				mx = monster_col(m);
				if (!aimed && !model_mask[m] && !pending[m] &&
					model_x >= mx - `ARENA_MONSTER_HALF_W &&
					model_x <= mx + `ARENA_MONSTER_HALF_W) begin
					aimed = 1'b1;
					pending[m] = 1'b1;
				end
			end
			release_q.push_back(cycle + (aimed ? hit_delay : miss_delay));
		end
		fire = 1'b1;
		tick();
		fire = 1'b0;
		tick();
	endtask

	task automatic pulse_next();
		level_next = 1'b1;
		tick();
		level_next = 1'b0;
		model_x = `ARENA_TANK_START_X;
		model_mask = '0;
		pending = '0;
		release_q.delete();
	endtask

	// pending hits have landed by now
	task automatic settle();
		model_score = arena_pkg::score_t'(model_score + count_bits(pending));
		model_mask = model_mask | pending;
		pending = '0;
	endtask

	task automatic check_pixel(input logic b, input int h, input int v,
		input arena_pkg::rgb_t expected);
		bright = b;
		hcount = arena_pkg::coord_t'(h);
		vcount = arena_pkg::coord_t'(v);
		#5;
		checks = checks + 1;
		assert (rgb == expected) else begin
			mismatches = mismatches + 1;
			$display("mismatch rgb at (%0d, %0d) bright %0d: expected %h, actual %h",
				h, v, b, expected, rgb);
		end
	endtask

	// right edge of the head pins the tank column
	task automatic check_tank();
		check_pixel(1'b1, model_x + 2, `ARENA_TANK_Y - 3, `ARENA_COLOR_GREEN);
		check_pixel(1'b1, model_x + 3, `ARENA_TANK_Y - 3, `ARENA_COLOR_BLACK);
	endtask

	task automatic check_state();
		checks = checks + 2;
		assert (score == model_score) else begin
			mismatches = mismatches + 1;
			$display("mismatch score: expected %h, actual %h", model_score, score);
		end
		assert (monster_destroyed == model_mask) else begin
			mismatches = mismatches + 1;
			$display("mismatch monster_destroyed: expected %h, actual %h",
				model_mask, monster_destroyed);
		end
	endtask

	initial begin
		seed = 32'h1a37;
		checks = 0;
		mismatches = 0;
		cycle = 0;
		rst = 1'b1;
		bright = 1'b0;
		left = 1'b0;
		right = 1'b0;
		fire = 1'b0;
		level_next = 1'b0;
		hcount = '0;
		vcount = '0;
		model_x = `ARENA_TANK_START_X;
		model_mask = '0;
		pending = '0;
		model_score = '0;
		#10;
		repeat (5) tick();
		rst = 1'b0;

		// after reset
		check_state();
		check_pixel(1'b0, 450, 452, `ARENA_COLOR_BLACK);
		check_pixel(1'b1, 450, 452, `ARENA_COLOR_GREEN);
		check_pixel(1'b1, 450, 100, `ARENA_COLOR_RED);
		check_pixel(1'b1, 50, 300, `ARENA_COLOR_BLACK);

		// straight up into monster 2
		press_fire();
		// shot one row above the tank row draws over the tank
		check_pixel(1'b1, 450, `ARENA_TANK_Y - 1, `ARENA_COLOR_BLUE);
		repeat (hit_wait) tick();
		settle();
		check_state();
		check_pixel(1'b1, 450, 100, `ARENA_COLOR_BLACK);

		// long right run wraps past the right edge
		n = 200 + ($unsigned($random(seed)) % 64);
		repeat (n) step_right();
		check_tank();
		n = $unsigned($random(seed)) % 128;
		repeat (n) step_left();
		check_tank();
		// column 300 lies between monsters 0 and 1
		move_to(300);
		check_tank();
		press_fire();
		repeat (miss_wait) tick();
		settle();
		check_state();

		// fourth shot finds every slot busy
		move_to(250);
		press_fire();
		move_to(350);
		press_fire();
		move_to(550);
		press_fire();
		move_to(650);
		press_fire();
		repeat (hit_wait) tick();
		settle();
		check_state();
		check_pixel(1'b1, 650, 100, `ARENA_COLOR_RED);
		check_pixel(1'b1, 250, 100, `ARENA_COLOR_BLACK);

		// last monster, then the cleared screen and a new level
		press_fire();
		repeat (hit_wait) tick();
		settle();
		check_state();
		check_pixel(1'b1, 450, 452, `ARENA_COLOR_CYAN);
		check_pixel(1'b1, 50, 300, `ARENA_COLOR_CYAN);
		check_pixel(1'b0, 50, 300, `ARENA_COLOR_BLACK);
		pulse_next();
		check_state();
		check_pixel(1'b1, 250, 100, `ARENA_COLOR_RED);
		check_pixel(1'b1, 650, 100, `ARENA_COLOR_RED);
		check_pixel(1'b1, 450, 452, `ARENA_COLOR_GREEN);

		$display("checks run: %0d, mismatches: %0d", checks, mismatches);
		if (mismatches == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/tank_arena.sv
`default_nettype none
`include "arena_config.svh"

module tank_arena (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           bright,
	input  wire                           left,
	input  wire                           right,
	input  wire                           fire,
	input  wire                           level_next,
	input  wire arena_pkg::coord_t        hcount,
	input  wire arena_pkg::coord_t        vcount,
	output arena_pkg::rgb_t               rgb,
	output arena_pkg::monster_mask_t      monster_destroyed,
	output arena_pkg::score_t             score
);

	logic fire_pulse;
	logic restart;
	logic cleared;
	arena_pkg::coord_t tank_x;
	arena_pkg::shot_mask_t shot_alive;
	arena_pkg::shot_mask_t hit_slots;
	arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0] shot_x;
	arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0] shot_y;

	game_ctrl ctrl_i (
		.clk               (clk),
		.rst               (rst),
		.fire              (fire),
		.level_next        (level_next),
		.hit_slots         (hit_slots),
		.monster_destroyed (monster_destroyed),
		.fire_pulse        (fire_pulse),
		.restart           (restart),
		.cleared           (cleared),
		.score             (score)
	);

	tank_mover tank_i (
		.clk        (clk),
		.rst        (rst),
		.restart    (restart),
		.left       (left),
		.right      (right),
		.fire_pulse (fire_pulse),
		.tank_x     (tank_x)
	);

	shot_slots shots_i (
		.clk        (clk),
		.rst        (rst),
		.restart    (restart),
		.fire_pulse (fire_pulse),
		.tank_x     (tank_x),
		.hit_slots  (hit_slots),
		.shot_alive (shot_alive),
		.shot_x     (shot_x),
		.shot_y     (shot_y)
	);

	monster_row monsters_i (
		.clk               (clk),
		.rst               (rst),
		.restart           (restart),
		.shot_alive        (shot_alive),
		.shot_x            (shot_x),
		.shot_y            (shot_y),
		.hit_slots         (hit_slots),
		.monster_destroyed (monster_destroyed)
	);

	pixel_renderer render_i (
		.bright            (bright),
		.hcount            (hcount),
		.vcount            (vcount),
		.cleared           (cleared),
		.tank_x            (tank_x),
		.shot_alive        (shot_alive),
		.shot_x            (shot_x),
		.shot_y            (shot_y),
		.monster_destroyed (monster_destroyed),
		.rgb               (rgb)
	);

endmodule

`default_nettype wire

// File: verilog/pixel_renderer.sv
`default_nettype none
`include "arena_config.svh"

module pixel_renderer (
	input  wire                                          bright,
	input  wire arena_pkg::coord_t                       hcount,
	input  wire arena_pkg::coord_t                       vcount,
	input  wire                                          cleared,
	input  wire arena_pkg::coord_t                       tank_x,
	input  wire arena_pkg::shot_mask_t                   shot_alive,
	input  wire arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0] shot_x,
	input  wire arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0] shot_y,
	input  wire arena_pkg::monster_mask_t                monster_destroyed,
	output arena_pkg::rgb_t                              rgb
);

	logic on_shot;
	logic on_tank;
	logic on_monster;
	logic tank_head;
	logic tank_body;

	// 3x3 box around each live shot
	always_comb begin
		on_shot = 1'b0;
		for (int s = 0; s < `ARENA_NUM_SHOTS; s++) begin
			if (shot_alive[s] &&
				vcount >= shot_y[s] - 1'b1 && vcount <= shot_y[s] + 1'b1 &&
				hcount >= shot_x[s] - 1'b1 && hcount <= shot_x[s] + 1'b1) begin
				on_shot = 1'b1;
			end
		end
	end

	// head sits on top of the body, 5 wide
	assign tank_head = vcount >= `ARENA_TANK_Y - 10'd5 && vcount < `ARENA_TANK_Y &&
		hcount >= tank_x - 10'd2 && hcount <= tank_x + 10'd2;
	assign tank_body = vcount >= `ARENA_TANK_Y && vcount <= `ARENA_TANK_Y + 10'd10 &&
		hcount >= tank_x - 10'd10 && hcount <= tank_x + 10'd10;
	assign on_tank = tank_head || tank_body;

	// 21x11 box per surviving monster
	always_comb begin : monster_shapes
		arena_pkg::coord_t mon_x;
		on_monster = 1'b0;
		for (int m = 0; m < `ARENA_NUM_MONSTERS; m++) begin
			mon_x = arena_pkg::coord_t'(`ARENA_MONSTER_X0 + `ARENA_MONSTER_PITCH * m);
			if (!monster_destroyed[m] &&
				vcount >= `ARENA_MONSTER_Y - `ARENA_MONSTER_HALF_H &&
				vcount <= `ARENA_MONSTER_Y + `ARENA_MONSTER_HALF_H &&
				hcount >= mon_x - `ARENA_MONSTER_HALF_W &&
				hcount <= mon_x + `ARENA_MONSTER_HALF_W) begin
				on_monster = 1'b1;
			end
		end
	end

	// blanking first, then cleared screen, then objects front to back
	always_comb begin
		if (!bright) begin
			rgb = `ARENA_COLOR_BLACK;
		end else if (cleared) begin
			rgb = `ARENA_COLOR_CYAN;
		end else if (on_shot) begin
			rgb = `ARENA_COLOR_BLUE;
		end else if (on_tank) begin
			rgb = `ARENA_COLOR_GREEN;
		end else if (on_monster) begin
			rgb = `ARENA_COLOR_RED;
		end else begin
			rgb = `ARENA_COLOR_BLACK;
		end
	end

endmodule

`default_nettype wire

// File: verilog/monster_row.sv
`default_nettype none
`include "arena_config.svh"

module monster_row (
	input  wire                                          clk,
	input  wire                                          rst,
	input  wire                                          restart,
	input  wire arena_pkg::shot_mask_t                   shot_alive,
	input  wire arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0] shot_x,
	input  wire arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0] shot_y,
	output arena_pkg::shot_mask_t                        hit_slots,
	output arena_pkg::monster_mask_t                     monster_destroyed
);

	arena_pkg::monster_mask_t hit_monsters;

	// every live shot against every surviving monster
	always_comb begin : hit_check
		arena_pkg::coord_t mon_x;
		logic match;
		hit_slots    = '0;
		hit_monsters = '0;
		for (int m = 0; m < `ARENA_NUM_MONSTERS; m++) begin
			mon_x = arena_pkg::coord_t'(`ARENA_MONSTER_X0 + `ARENA_MONSTER_PITCH * m);
			for (int s = 0; s < `ARENA_NUM_SHOTS; s++) begin
				match = shot_alive[s] && !monster_destroyed[m] &&
					(shot_y[s] == `ARENA_MONSTER_Y) &&
					(shot_x[s] >= mon_x - `ARENA_MONSTER_HALF_W) &&
					(shot_x[s] <= mon_x + `ARENA_MONSTER_HALF_W);
				if (match) begin
					hit_slots[s]    = 1'b1;
					hit_monsters[m] = 1'b1;
				end
			end
		end
	end

	// destroyed flags only ever set until the next restart
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			monster_destroyed <= '0;
		end else if (restart) begin
			monster_destroyed <= '0;
		end else begin
			monster_destroyed <= monster_destroyed | hit_monsters;
		end
	end

endmodule

`default_nettype wire

// File: verilog/shot_slots.sv
`default_nettype none
`include "arena_config.svh"

module shot_slots (
	input  wire                                          clk,
	input  wire                                          rst,
	input  wire                                          restart,
	input  wire                                          fire_pulse,
	input  wire arena_pkg::coord_t                       tank_x,
	input  wire arena_pkg::shot_mask_t                   hit_slots,
	output arena_pkg::shot_mask_t                        shot_alive,
	output arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0]     shot_x,
	output arena_pkg::coord_t [`ARENA_NUM_SHOTS-1:0]     shot_y
);

	arena_pkg::shot_mask_t free_slots;
	arena_pkg::shot_mask_t launch;
	arena_pkg::shot_mask_t retire;

	assign free_slots = ~shot_alive;

	// lowest free slot only, nothing when all slots fly
	assign launch = fire_pulse ? (free_slots & (~free_slots + 1'b1)) : '0;

	// a shot leaves on a hit or at the top row
	always_comb begin
		for (int i = 0; i < `ARENA_NUM_SHOTS; i++) begin
			retire[i] = hit_slots[i] || (shot_alive[i] && shot_y[i] == `ARENA_SHOT_TOP);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shot_alive <= '0;
			for (int i = 0; i < `ARENA_NUM_SHOTS; i++) begin
				shot_x[i] <= `ARENA_PARK_X;
				shot_y[i] <= `ARENA_TANK_Y;
			end
		end else begin
			for (int i = 0; i < `ARENA_NUM_SHOTS; i++) begin
				if (restart || retire[i]) begin
					// idle slot parks off screen on the tank row
					shot_alive[i] <= 1'b0;
					shot_x[i]     <= `ARENA_PARK_X;
					shot_y[i]     <= `ARENA_TANK_Y;
				end else if (launch[i]) begin
					shot_alive[i] <= 1'b1;
					shot_x[i]     <= tank_x;
					shot_y[i]     <= `ARENA_TANK_Y;
				end else if (shot_alive[i]) begin
					// one row up per cycle
					shot_y[i] <= shot_y[i] - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/tank_mover.sv
`default_nettype none
`include "arena_config.svh"

module tank_mover (
	input  wire                clk,
	input  wire                rst,
	input  wire                restart,
	input  wire                left,
	input  wire                right,
	input  wire                fire_pulse,
	output arena_pkg::coord_t  tank_x
);

	// tank holds still in a fire cycle, right wins over left
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tank_x <= `ARENA_TANK_START_X;
		end else if (restart) begin
			tank_x <= `ARENA_TANK_START_X;
		end else if (fire_pulse) begin
			tank_x <= tank_x;
		end else if (right) begin
			// wrap to the left edge
			if (tank_x == `ARENA_X_MAX) begin
				tank_x <= `ARENA_X_MIN;
			end else begin
				tank_x <= tank_x + `ARENA_TANK_STEP;
			end
		end else if (left) begin
			// wrap to the right edge
			if (tank_x == `ARENA_X_MIN) begin
				tank_x <= `ARENA_X_MAX;
			end else begin
				tank_x <= tank_x - `ARENA_TANK_STEP;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/game_ctrl.sv
`default_nettype none
`include "arena_config.svh"

module game_ctrl (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           fire,
	input  wire                           level_next,
	input  wire arena_pkg::shot_mask_t    hit_slots,
	input  wire arena_pkg::monster_mask_t monster_destroyed,
	output logic                          fire_pulse,
	output logic                          restart,
	output logic                          cleared,
	output arena_pkg::score_t             score
);

	arena_pkg::game_state_e state;
	logic fire_prev;
	logic all_destroyed;

	// next level acts in the same cycle it is seen
	assign restart = level_next;

	// single cycle pulse on the rising edge of fire
	assign fire_pulse = fire && !fire_prev;

	assign all_destroyed = (monster_destroyed == {`ARENA_NUM_MONSTERS{1'b1}});
	assign cleared = (state == arena_pkg::st_cleared);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fire_prev <= 1'b0;
		end else begin
			fire_prev <= fire;
		end
	end

	// play until the whole row is gone
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= arena_pkg::st_play;
		end else if (restart) begin
			state <= arena_pkg::st_play;
		end else if (state == arena_pkg::st_play && all_destroyed) begin
			state <= arena_pkg::st_cleared;
		end
	end

	// score survives a restart, only reset clears it
	// slots can't hit two monsters at once, so one step per cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			score <= '0;
		end else if (!restart && (|hit_slots)) begin
			score <= score + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/arena_pkg.sv
`default_nettype none
`include "arena_config.svh"

package arena_pkg;

	// screen position, wide enough for the parked column
	typedef logic [9:0] coord_t;

	typedef logic [11:0] rgb_t;

	// one bit per shot slot
	typedef logic [`ARENA_NUM_SHOTS-1:0] shot_mask_t;

	// one bit per monster, set once destroyed
	typedef logic [`ARENA_NUM_MONSTERS-1:0] monster_mask_t;

	typedef logic [2:0] score_t;

	typedef enum logic {
		st_play,
		st_cleared
	} game_state_e;

endpackage

`default_nettype wire

// File: include/arena_config.svh
`ifndef ARENA_CONFIG_SVH
`define ARENA_CONFIG_SVH

// object counts
`define ARENA_NUM_SHOTS       3
`define ARENA_NUM_MONSTERS    5

// tank placement and motion
`define ARENA_TANK_START_X    10'd450
`define ARENA_TANK_Y          10'd450
`define ARENA_TANK_STEP       10'd2

// horizontal wrap limits of the tank
`define ARENA_X_MIN           10'd150
`define ARENA_X_MAX           10'd800

// monster k sits at column x0 + pitch * k
`define ARENA_MONSTER_Y       10'd100
`define ARENA_MONSTER_X0      10'd250
`define ARENA_MONSTER_PITCH   10'd100
`define ARENA_MONSTER_HALF_W  10'd10
`define ARENA_MONSTER_HALF_H  10'd5

// shot retire row and parking spot of an idle shot
`define ARENA_SHOT_TOP        10'd33
`define ARENA_PARK_X          10'd1000

// 4 bits each of red, green, blue
`define ARENA_COLOR_BLACK     12'h000
`define ARENA_COLOR_GREEN     12'h0f0
`define ARENA_COLOR_BLUE      12'h00f
`define ARENA_COLOR_RED       12'hf00
`define ARENA_COLOR_CYAN      12'h0ff

`endif
